// File: include/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Instruction ROM size in 32-bit words
`define ROM_WORDS 128

// Cache line geometry
`define LINE_WORDS 4

// Line buffer depth, also the number of fetch credits
`define BUF_LINES 4

// Default ROM response latency in cycles
`define ROM_LATENCY 2

// RISC-V major opcodes used by the ROM image and the predecoder
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011

`endif

// File: src/fetch_pkg.sv
`include "fetch_defines.svh"

package fetch_pkg;

    typedef logic [31:0] t_word;

    // Top bit is the epoch, low bits are the line sequence number
    typedef logic [3:0] t_reqId;

    typedef struct packed {
        logic   valid;
        t_reqId id;
        t_word  addr;
    } t_memReq;

    typedef t_word [`LINE_WORDS-1:0] t_line;

    // Address is echoed back so the buffer can find the start offset
    typedef struct packed {
        logic   valid;
        t_reqId id;
        t_word  addr;
        t_line  data;
    } t_memRsp;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } t_rType;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } t_iType;

    typedef union packed {
        t_rType r;
        t_iType i;
        t_word  raw;
    } t_instr;

    typedef struct packed {
        logic       valid;
        t_word      pc;
        logic       isImm;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        t_word      imm;
        t_word      raw;
    } t_decoded;

    // Every fourth word is an XOR, the rest are ADDIs with varied immediates
    function automatic t_word romWord(input int index);
        t_instr instr;
        if ((index % 4) == 3) begin
            instr.r.funct7 = 7'b0000000;
            instr.r.rs2    = 5'(5 * index);
            instr.r.rs1    = 5'(3 * index);
            instr.r.funct3 = 3'b100;
            instr.r.rd     = 5'(index);
            instr.r.opcode = `OPC_OP;
        end else begin
            instr.i.imm12  = 12'(37 * index);
            instr.i.rs1    = 5'(7 * index);
            instr.i.funct3 = 3'b000;
            instr.i.rd     = 5'(index);
            instr.i.opcode = `OPC_OP_IMM;
        end
        return instr.raw;
    endfunction

endpackage

// File: src/fetchSequencer.sv
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetchSequencer (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  fetch_pkg::t_word   startPc,
    input  logic               lineFreed,
    output fetch_pkg::t_memReq req,
    output logic               epoch
);

    localparam int CREDIT_BITS = $clog2(`BUF_LINES + 1);
    localparam int LINE_BYTES  = `LINE_WORDS * 4;
    localparam int ROM_BYTES   = `ROM_WORDS * 4;

    logic                   active;
    logic [CREDIT_BITS-1:0] credit;
    logic [2:0]             seq;
    fetch_pkg::t_word       nextAddr;
    fetch_pkg::t_word       lineAddrNext;
    logic                   issue;

    // One request per cycle as long as the buffer has room for it
    assign issue = active && (credit != '0);

    // Step to the following line, wrapping at the end of the ROM
    assign lineAddrNext = ((nextAddr & ~32'(LINE_BYTES - 1)) + 32'(LINE_BYTES))
                          & 32'(ROM_BYTES - 1);

    always_comb begin
        req.valid = issue;
        req.id    = {epoch, seq};
        req.addr  = nextAddr;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            epoch  <= 1'b0;
            credit <= '0;
            seq    <= '0;
        end else if (start) begin
            // New stream, anything still outstanding is now stale
            active <= 1'b1;
            epoch  <= ~epoch;
            credit <= CREDIT_BITS'(`BUF_LINES);
            seq    <= '0;
        end else begin
            if (issue) begin
                seq <= seq + 3'd1;
            end
            credit <= credit - CREDIT_BITS'(issue) + CREDIT_BITS'(lineFreed);
        end
    end

    // First request keeps the exact start PC, later ones are line aligned
    always_ff @(posedge clk) begin
        if (start) begin
            nextAddr <= startPc;
        end else if (issue) begin
            nextAddr <= lineAddrNext;
        end
    end

endmodule

// File: src/instrRom.sv
`timescale 1ns/1ps
`include "fetch_defines.svh"

module instrRom #(
    parameter int LATENCY = `ROM_LATENCY
) (
    input  logic               clk,
    input  logic               reset,
    input  fetch_pkg::t_memReq req,
    output fetch_pkg::t_memRsp rsp
);

    localparam int IDX_BITS = $clog2(`ROM_WORDS);

    fetch_pkg::t_word   rom [`ROM_WORDS];
    fetch_pkg::t_memRsp rspPipe [LATENCY];

    logic [IDX_BITS-1:0] wordIdx;
    logic [IDX_BITS-1:0] lineIdx;

    // Image comes from the shared generator function
    initial begin
        for (int i = 0; i < `ROM_WORDS; i++) begin
            rom[i] = fetch_pkg::romWord(i);
        end
    end

    assign wordIdx = req.addr[2 +: IDX_BITS];
    assign lineIdx = wordIdx & ~IDX_BITS'(`LINE_WORDS - 1);

    // Registered lookup of a whole line
    always_ff @(posedge clk) begin
        for (int w = 0; w < `LINE_WORDS; w++) begin
            rspPipe[0].data[w] <= rom[IDX_BITS'(lineIdx + w)];
        end
        rspPipe[0].id   <= req.id;
        rspPipe[0].addr <= req.addr;
        if (reset) begin
            rspPipe[0].valid <= 1'b0;
        end else begin
            rspPipe[0].valid <= req.valid;
        end
    end

    // Extra delay stages, several requests may be in flight
    for (genvar s = 1; s < LATENCY; s++) begin : gStage
        always_ff @(posedge clk) begin
            rspPipe[s] <= rspPipe[s-1];
            if (reset) begin
                rspPipe[s].valid <= 1'b0;
            end
        end
    end

    assign rsp = rspPipe[LATENCY-1];

endmodule

// File: src/lineBuffer.sv
`timescale 1ns/1ps
`include "fetch_defines.svh"

module lineBuffer (
    input  logic               clk,
    input  logic               reset,
    input  fetch_pkg::t_memRsp rsp,
    input  logic               epoch,
    input  logic               take,
    output fetch_pkg::t_word   word,
    output fetch_pkg::t_word   wordPc,
    output logic               wordValid,
    output logic               lineFreed
);

    localparam int PTR_BITS = $clog2(`BUF_LINES);
    localparam int OFF_BITS = $clog2(`LINE_WORDS);
    localparam int CNT_BITS = $clog2(`BUF_LINES + 1);

    fetch_pkg::t_line    lineData [`BUF_LINES];
    fetch_pkg::t_word    lineBase [`BUF_LINES];
    logic [OFF_BITS-1:0] lineOff  [`BUF_LINES];

    logic [PTR_BITS-1:0] head;
    logic [PTR_BITS-1:0] tail;
    logic [PTR_BITS-1:0] nextHead;
    logic [CNT_BITS-1:0] count;
    logic [OFF_BITS-1:0] wordPtr;
    logic [OFF_BITS-1:0] rspOff;
    logic [OFF_BITS-1:0] nextOff;
    logic                epochQ;
    logic                flush;
    logic                keep;
    logic                advance;
    logic                lastWord;

    // Epoch toggle means a restart, queued lines are stale
    assign flush = (epoch != epochQ);
    assign keep  = rsp.valid && (rsp.id[3] == epoch);

    assign rspOff   = rsp.addr[2 +: OFF_BITS];
    assign nextHead = head + PTR_BITS'(1);
    // With one line left the next head is the line landing this cycle
    assign nextOff  = (count > CNT_BITS'(1)) ? lineOff[nextHead] : rspOff;

    assign wordValid = (count != '0) && !flush;
    assign advance   = take && wordValid;
    assign lastWord  = (wordPtr == OFF_BITS'(`LINE_WORDS - 1));
    assign lineFreed = advance && lastWord;

    assign word   = lineData[head][wordPtr];
    assign wordPc = lineBase[head] + (32'(wordPtr) << 2);

    always_ff @(posedge clk) begin
        if (keep) begin
            lineData[tail] <= rsp.data;
            lineBase[tail] <= rsp.addr & ~32'(`LINE_WORDS * 4 - 1);
            lineOff[tail]  <= rspOff;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            wordPtr <= '0;
            epochQ  <= 1'b0;
        end else begin
            epochQ <= epoch;
            if (flush) begin
                head  <= tail;
                count <= CNT_BITS'(keep);
                if (keep) begin
                    tail    <= tail + PTR_BITS'(1);
                    wordPtr <= rspOff;
                end
            end else begin
                if (keep) begin
                    tail <= tail + PTR_BITS'(1);
                end
                if (lineFreed) begin
                    head <= nextHead;
                end
                count <= count + CNT_BITS'(keep) - CNT_BITS'(lineFreed);
                if (advance) begin
                    wordPtr <= lastWord ? nextOff : wordPtr + OFF_BITS'(1);
                end else if (keep && count == '0) begin
                    wordPtr <= rspOff;
                end
            end
        end
    end

endmodule

// File: src/preDecoder.sv
`timescale 1ns/1ps
`include "fetch_defines.svh"

module preDecoder (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  fetch_pkg::t_word    word,
    input  fetch_pkg::t_word    wordPc,
    input  logic                wordValid,
    output logic                take,
    output fetch_pkg::t_decoded instOut
);

    fetch_pkg::t_instr   view;
    fetch_pkg::t_decoded decoded;

    // Output register loads whenever it is not stalled
    assign take = !stall;

    always_comb begin
        view          = word;
        decoded.valid = wordValid;
        decoded.pc    = wordPc;
        decoded.raw   = word;
        // rd and rs1 sit in the same place in both formats
        decoded.rd    = view.r.rd;
        decoded.rs1   = view.r.rs1;
        if (view.r.opcode == `OPC_OP) begin
            decoded.isImm = 1'b0;
            decoded.rs2   = view.r.rs2;
            decoded.imm   = '0;
        end else begin
            decoded.isImm = 1'b1;
            decoded.rs2   = '0;
            decoded.imm   = {{20{view.i.imm12[11]}}, view.i.imm12};
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            instOut <= decoded;
        end
        if (reset) begin
            instOut.valid <= 1'b0;
        end
    end

endmodule

// File: src/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  fetch_pkg::t_word    startPc,
    input  logic                stall,
    output fetch_pkg::t_decoded instOut
);

    fetch_pkg::t_memReq req;
    fetch_pkg::t_memRsp rsp;
    fetch_pkg::t_word   word;
    fetch_pkg::t_word   wordPc;
    logic               epoch;
    logic               lineFreed;
    logic               wordValid;
    logic               take;

    fetchSequencer sequencer (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .startPc   (startPc),
        .lineFreed (lineFreed),
        .req       (req),
        .epoch     (epoch)
    );

    instrRom rom (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .rsp   (rsp)
    );

    lineBuffer buffer (
        .clk       (clk),
        .reset     (reset),
        .rsp       (rsp),
        .epoch     (epoch),
        .take      (take),
        .word      (word),
        .wordPc    (wordPc),
        .wordValid (wordValid),
        .lineFreed (lineFreed)
    );

    preDecoder decoder (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .word      (word),
        .wordPc    (wordPc),
        .wordValid (wordValid),
        .take      (take),
        .instOut   (instOut)
    );

endmodule

// File: test/fetchUnit_tb.sv
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetchUnit_tb;

    localparam int CLK_PERIOD      = 4;
    localparam int IDLE_CYCLES     = 8;
    localparam int DIRECTED_CYCLES = 40;
    localparam int NUM_STARTS      = 60;
    localparam int MAX_GAP         = 2 + 63;
    localparam int DRAIN_CYCLES    = 60;
    localparam int WATCHDOG_CYCLES = IDLE_CYCLES + DIRECTED_CYCLES + NUM_STARTS * MAX_GAP
                                     + DRAIN_CYCLES + 200;

    logic                clk;
    logic                reset;
    logic                start;
    fetch_pkg::t_word    startPc;
    logic                stall;
    fetch_pkg::t_decoded instOut;

    // Model state
    logic [15:0]         lfsrState;
    logic                appliedStart;
    logic                appliedStall;
    fetch_pkg::t_word    appliedPc;
    logic                started;
    fetch_pkg::t_word    expPc;
    fetch_pkg::t_decoded prevOut;
    int                  segmentWords;
    int                  errorCount;

    fetchUnit UUT (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .startPc (startPc),
        .stall   (stall),
        .instOut (instOut)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Simulation timed out after %0d cycles without finishing", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $fatal(1, "Watchdog expired");
    end

    function automatic logic [15:0] nextLfsr(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic int randomBits(input int count);
        int value;
        value = 0;
        for (int b = 0; b < count; b++) begin
            value = (value << 1) | int'(lfsrState[0]);
            lfsrState = nextLfsr(lfsrState);
        end
        return value;
    endfunction

    // About 30 percent stalled
    function automatic logic randomStall();
        return randomBits(4) < 5;
    endfunction

    // Expected decode built straight from the ROM image rules
    function automatic fetch_pkg::t_decoded expectedInstr(input fetch_pkg::t_word pc);
        fetch_pkg::t_decoded exp;
        int                  idx;
        int                  imm12;
        idx       = int'(pc >> 2) % `ROM_WORDS;
        exp.valid = 1'b1;
        exp.pc    = pc;
        exp.rd    = 5'(idx % 32);
        if ((idx % 4) == 3) begin
            exp.isImm = 1'b0;
            exp.rs1   = 5'((3 * idx) % 32);
            exp.rs2   = 5'((5 * idx) % 32);
            exp.imm   = '0;
            exp.raw   = {7'b0000000, exp.rs2, exp.rs1, 3'b100, exp.rd, 7'b0110011};
        end else begin
            imm12     = (37 * idx) % 4096;
            exp.isImm = 1'b1;
            exp.rs1   = 5'((7 * idx) % 32);
            exp.rs2   = '0;
            exp.imm   = (imm12 >= 2048) ? imm12 - 4096 : imm12;
            exp.raw   = {12'(imm12), exp.rs1, 3'b000, exp.rd, 7'b0010011};
        end
        return exp;
    endfunction

    task automatic check(input logic [127:0] actual, input logic [127:0] expected,
                         input string what);
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED at %0.3f ns: %s, got %0h expected %0h",
                     $realtime, what, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // Looks at what the last rising edge loaded
    task automatic checkOutput();
        fetch_pkg::t_decoded expected;
        if (appliedStall) begin
            check(128'(instOut), 128'(prevOut), "output changed while stalled");
        end else if (instOut.valid) begin
            check(128'(started), 128'(1'b1), "valid output before the first start");
            expected = expectedInstr(expPc);
            check(128'(instOut.pc), 128'(expPc), "instruction out of program order");
            check(128'(instOut), 128'(expected),
                  $sformatf("decode mismatch at pc %0h", expPc));
            expPc = (expPc + 32'd4) & 32'(`ROM_WORDS * 4 - 1);
            segmentWords++;
        end
        // Words loaded on the start edge itself still belong to the old stream
        if (appliedStart) begin
            expPc        = appliedPc;
            started      = 1'b1;
            segmentWords = 0;
        end
        prevOut = instOut;
    endtask

    task automatic runCycle(input logic startIn, input fetch_pkg::t_word pcIn,
                            input logic stallIn);
        @(negedge clk);
        checkOutput();
        start        = startIn;
        startPc      = pcIn;
        stall        = stallIn;
        appliedStart = startIn;
        appliedPc    = pcIn;
        appliedStall = stallIn;
    endtask

    initial begin
        fetch_pkg::t_word pc;
        int               gap;
        lfsrState    = 16'd56021;
        reset        = 1'b1;
        start        = 1'b0;
        startPc      = '0;
        stall        = 1'b0;
        appliedStart = 1'b0;
        appliedStall = 1'b0;
        appliedPc    = '0;
        started      = 1'b0;
        expPc        = '0;
        segmentWords = 0;
        errorCount   = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset   = 1'b0;
        prevOut = instOut;

        // Nothing may come out before the first start
        repeat (IDLE_CYCLES) runCycle(1'b0, '0, 1'b0);

        // Start near the top of the ROM so the stream wraps to word 0
        runCycle(1'b1, 32'd500, 1'b0);
        repeat (DIRECTED_CYCLES - 1) runCycle(1'b0, '0, 1'b0);
        check(128'(segmentWords >= 25), 128'(1'b1), "too few words after the wrap start");

        // Random restarts with lines often still in flight
        for (int n = 0; n < NUM_STARTS; n++) begin
            pc  = 32'(randomBits(7) * 4);
            gap = 2 + randomBits(6);
            runCycle(1'b1, pc, randomStall());
            for (int c = 1; c < gap; c++) begin
                runCycle(1'b0, '0, randomStall());
            end
        end

        repeat (DRAIN_CYCLES) runCycle(1'b0, '0, 1'b0);
        check(128'(segmentWords >= 40), 128'(1'b1), "stream stopped during the drain");

        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
src/fetch_pkg.sv
src/fetchSequencer.sv
src/instrRom.sv
src/lineBuffer.sv
src/preDecoder.sv
src/fetchUnit.sv
test/fetchUnit_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module fetchUnit_tb -f vlog.f -o VfetchUnit_tb

./obj_dir/VfetchUnit_tb | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
